// ==== dbg_pkg.sv ====
`default_nettype none

package dbg_pkg;

    // capture memory geometry
    localparam int sample_depth = 256;
    localparam int addr_w       = 8;    // log2 of sample_depth
    localparam int cnt_w        = 8;    // readout count minus one

    // transmit side
    localparam int tx_w = 32;

    // register bus
    localparam int axi_addr_w = 5;
    localparam int axi_data_w = 32;

    localparam logic [axi_addr_w-1:0] reg_ctrl    = 5'h00;  // arm pulses, write only
    localparam logic [axi_addr_w-1:0] reg_status  = 5'h04;  // done flags and busy
    localparam logic [axi_addr_w-1:0] reg_rd_addr = 5'h08;
    localparam logic [axi_addr_w-1:0] reg_rd_cfg  = 5'h0C;  // count minus one and mode
    localparam logic [axi_addr_w-1:0] reg_start   = 5'h10;  // readout kick, write only

    localparam logic [1:0] axi_resp_okay   = 2'd0;
    localparam logic [1:0] axi_resp_slverr = 2'd2;

    // channel A probe, one full word
    typedef logic [31:0] probe_a_t;

    // channel B probe
    typedef struct packed {
        logic [7:0] event_code;  // upper byte
        logic [7:0] flags;       // lower byte
    } probe_b_t;

    // readout selection, zero means nothing to stream
    typedef enum logic [1:0] {
        mode_a  = 2'd1,
        mode_b  = 2'd2,
        mode_ab = 2'd3   // A then B for each address
    } readout_mode_t;

endpackage

`default_nettype wire

// ==== dbg_buf_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// link between register block, one capture buffer and the readout engine
interface dbg_buf_if #(
    parameter type sample_t = dbg_pkg::probe_a_t
);
    import dbg_pkg::*;

    logic              arm;      // single-cycle request to start a capture
    logic              done;     // level, set once the window is full
    logic              rd_en;
    logic [addr_w-1:0] rd_addr;
    sample_t           rd_data;  // one cycle after rd_en

    modport regs (
        output arm,
        input  done
    );

    modport buffer (
        input  arm,
        output done,
        input  rd_en,
        input  rd_addr,
        output rd_data
    );

    modport reader (
        output rd_en,
        output rd_addr,
        input  rd_data
    );

endinterface

`default_nettype wire

// ==== dbg_axil_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module dbg_axil_regs (
    input  wire                                txclk,
    input  wire                                rstn,
    // AXI4-Lite slave
    input  wire  [dbg_pkg::axi_addr_w-1:0]     awaddr,
    input  wire                                awvalid,
    output logic                               awready,
    input  wire  [dbg_pkg::axi_data_w-1:0]     wdata,
    input  wire  [dbg_pkg::axi_data_w/8-1:0]   wstrb,
    input  wire                                wvalid,
    output logic                               wready,
    output logic [1:0]                         bresp,
    output logic                               bvalid,
    input  wire                                bready,
    input  wire  [dbg_pkg::axi_addr_w-1:0]     araddr,
    input  wire                                arvalid,
    output logic                               arready,
    output logic [dbg_pkg::axi_data_w-1:0]     rdata,
    output logic [1:0]                         rresp,
    output logic                               rvalid,
    input  wire                                rready,
    // capture channels
    dbg_buf_if.regs                            buf_a,
    dbg_buf_if.regs                            buf_b,
    // readout request
    output logic                               start,
    output logic [dbg_pkg::addr_w-1:0]         rd_addr,
    output logic [dbg_pkg::cnt_w-1:0]          rd_count_m1,
    output dbg_pkg::readout_mode_t             mode,
    input  wire                                busy
);
    import dbg_pkg::*;

    logic                  wr_hs;     // address and data taken together
    logic                  rd_hs;
    logic                  wr_known;
    logic                  rd_known;
    logic [axi_data_w-1:0] rd_word;

    assign wr_hs   = awvalid && wvalid && !bvalid;
    assign awready = wr_hs;
    assign wready  = wr_hs;
    assign rd_hs   = arvalid && !rvalid;
    assign arready = !rvalid;

    assign wr_known = awaddr inside {reg_ctrl, reg_status, reg_rd_addr, reg_rd_cfg, reg_start};

    // write side, pulses last exactly one cycle
    always_ff @(posedge txclk or negedge rstn) begin
        if (!rstn) begin
            bvalid      <= 1'b0;
            buf_a.arm   <= 1'b0;
            buf_b.arm   <= 1'b0;
            start       <= 1'b0;
            rd_addr     <= '0;
            rd_count_m1 <= '0;
            mode        <= readout_mode_t'(2'd0);
        end else begin
            buf_a.arm <= 1'b0;
            buf_b.arm <= 1'b0;
            start     <= 1'b0;
            if (bvalid && bready)
                bvalid <= 1'b0;
            if (wr_hs) begin
                bvalid <= 1'b1;
                case (awaddr)
                    reg_ctrl: begin
                        if (wstrb[0]) begin
                            buf_a.arm <= wdata[0];
                            buf_b.arm <= wdata[1];
                        end
                    end
                    reg_rd_addr: begin
                        if (wstrb[0])
                            rd_addr <= wdata[addr_w-1:0];
                    end
                    reg_rd_cfg: begin
                        if (wstrb[0])
                            rd_count_m1 <= wdata[cnt_w-1:0];
                        if (wstrb[1])
                            mode <= readout_mode_t'(wdata[9:8]);
                    end
                    reg_start: begin
                        if (wstrb[0])
                            start <= wdata[0];
                    end
                    default: ;  // status is read only
                endcase
            end
        end
    end

    always_ff @(posedge txclk) begin
        if (wr_hs)
            bresp <= wr_known ? axi_resp_okay : axi_resp_slverr;
    end

    // read mux
    always_comb begin
        rd_word  = '0;
        rd_known = 1'b1;
        case (araddr)
            reg_ctrl, reg_start: rd_word = '0;  // write only, reads as zero
            reg_status:  rd_word[2:0]        = {busy, buf_b.done, buf_a.done};
            reg_rd_addr: rd_word[addr_w-1:0] = rd_addr;
            reg_rd_cfg:  rd_word[9:0]        = {mode, rd_count_m1};
            default:     rd_known            = 1'b0;
        endcase
    end

    always_ff @(posedge txclk or negedge rstn) begin
        if (!rstn)
            rvalid <= 1'b0;
        else if (rd_hs)
            rvalid <= 1'b1;
        else if (rready)
            rvalid <= 1'b0;
    end

    always_ff @(posedge txclk) begin
        if (rd_hs) begin
            rdata <= rd_word;
            rresp <= rd_known ? axi_resp_okay : axi_resp_slverr;
        end
    end

endmodule

`default_nettype wire

// ==== dbg_sample_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module dbg_sample_buffer #(
    parameter type sample_t = dbg_pkg::probe_a_t
) (
    input  wire      txclk,
    input  wire      rstn,
    input  sample_t  probe,
    input  wire      trig,
    dbg_buf_if.buffer bus
);
    import dbg_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_wait,   // armed, looking for a trigger edge
        st_cap
    } state_t;

    state_t            state;
    logic              trig_d;   // trigger from the previous cycle
    logic              trig_rise;
    logic [addr_w-1:0] wr_cnt;
    logic              wr_en;
    logic [addr_w-1:0] wr_ptr;

    sample_t mem [sample_depth];

    assign trig_rise = trig && !trig_d;

    // edge cycle itself is sample 0
    assign wr_en  = !bus.arm && ((state == st_wait && trig_rise) || state == st_cap);
    assign wr_ptr = (state == st_cap) ? wr_cnt : '0;

    always_ff @(posedge txclk or negedge rstn) begin
        if (!rstn) begin
            state    <= st_idle;
            trig_d   <= 1'b0;
            wr_cnt   <= '0;
            bus.done <= 1'b0;
        end else begin
            trig_d <= trig;
            if (bus.arm) begin
                state    <= st_wait;   // re-arm restarts from any state
                bus.done <= 1'b0;
                wr_cnt   <= '0;
            end else begin
                case (state)
                    st_wait: begin
                        if (trig_rise) begin
                            state  <= st_cap;
                            wr_cnt <= addr_w'(1);
                        end
                    end
                    st_cap: begin
                        wr_cnt <= wr_cnt + 1'b1;
                        if (wr_cnt == addr_w'(sample_depth - 1)) begin
                            state    <= st_idle;
                            bus.done <= 1'b1;  // last sample just written
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge txclk) begin
        if (wr_en)
            mem[wr_ptr] <= probe;
    end

    // registered read, usable in every state
    always_ff @(posedge txclk) begin
        if (bus.rd_en)
            bus.rd_data <= mem[bus.rd_addr];
    end

endmodule

`default_nettype wire

// ==== dbg_readout.sv ====
`timescale 1ns/1ps
`default_nettype none

module dbg_readout (
    input  wire                           txclk,
    input  wire                           rstn,
    input  wire                           start,
    input  wire  [dbg_pkg::addr_w-1:0]    rd_addr,
    input  wire  [dbg_pkg::cnt_w-1:0]     rd_count_m1,
    input  wire  dbg_pkg::readout_mode_t  mode,
    output logic                          busy,
    dbg_buf_if.reader                     buf_a,
    dbg_buf_if.reader                     buf_b,
    input  wire                           tx_ready,
    output logic                          tx_datavalid,
    output logic                          tx_datalast,
    output logic [dbg_pkg::tx_w-1:0]      tx_portdata
);
    import dbg_pkg::*;

    logic              accept;
    logic              issuing;     // reads still to be issued
    logic [cnt_w:0]    words_left;  // remaining reads minus one
    logic [addr_w-1:0] addr_q;
    logic              chan_b;      // next read goes to channel B
    logic              ab_q;        // interleaved request
    logic              rd_issue;
    logic              rd_pend;     // read data arrives this cycle
    logic              pend_b;
    logic              pend_last;
    logic [tx_w-1:0]   push_data;
    logic              pop;

    // two-entry output queue
    logic [tx_w-1:0]   q_data [2];
    logic              q_last [2];
    logic              q_wp;
    logic              q_rp;
    logic [1:0]        q_cnt;

    assign accept = start && !busy && (mode inside {mode_a, mode_b, mode_ab});
    assign pop    = tx_datavalid && tx_ready;

    // queued plus in-flight words never exceed two
    assign rd_issue = issuing && ((q_cnt + rd_pend - pop) < 2'd2);

    assign buf_a.rd_en   = rd_issue && !chan_b;
    assign buf_b.rd_en   = rd_issue && chan_b;
    assign buf_a.rd_addr = addr_q;
    assign buf_b.rd_addr = addr_q;

    always_ff @(posedge txclk or negedge rstn) begin
        if (!rstn) begin
            busy       <= 1'b0;
            issuing    <= 1'b0;
            words_left <= '0;
            addr_q     <= '0;
            chan_b     <= 1'b0;
            ab_q       <= 1'b0;
            rd_pend    <= 1'b0;
        end else begin
            rd_pend <= rd_issue;
            if (accept) begin
                busy       <= 1'b1;
                issuing    <= 1'b1;
                addr_q     <= rd_addr;
                chan_b     <= (mode == mode_b);
                ab_q       <= (mode == mode_ab);
                words_left <= (mode == mode_ab) ? {rd_count_m1, 1'b1} : {1'b0, rd_count_m1};
            end else if (rd_issue) begin
                words_left <= words_left - 1'b1;
                if (words_left == '0)
                    issuing <= 1'b0;
                if (ab_q && !chan_b) begin
                    chan_b <= 1'b1;            // B word of the same address
                end else begin
                    chan_b <= ab_q ? 1'b0 : chan_b;
                    addr_q <= addr_q + 1'b1;   // wraps at sample_depth
                end
            end
            if (pop && tx_datalast)
                busy <= 1'b0;
        end
    end

    always_ff @(posedge txclk) begin
        if (rd_issue) begin
            pend_b    <= chan_b;
            pend_last <= (words_left == '0);
        end
    end

    // widen, B is zero-extended
    assign push_data = pend_b ? {{(tx_w - $bits(buf_b.rd_data)){1'b0}}, buf_b.rd_data}
                              : tx_w'(buf_a.rd_data);

    always_ff @(posedge txclk) begin
        if (rd_pend) begin
            q_data[q_wp] <= push_data;
            q_last[q_wp] <= pend_last;
        end
    end

    always_ff @(posedge txclk or negedge rstn) begin
        if (!rstn) begin
            q_wp  <= 1'b0;
            q_rp  <= 1'b0;
            q_cnt <= 2'd0;
        end else begin
            if (rd_pend)
                q_wp <= ~q_wp;
            if (pop)
                q_rp <= ~q_rp;
            q_cnt <= q_cnt + rd_pend - pop;
        end
    end

    // head entry stays put until it transfers
    assign tx_datavalid = (q_cnt != 2'd0);
    assign tx_datalast  = tx_datavalid && q_last[q_rp];
    assign tx_portdata  = q_data[q_rp];

endmodule

`default_nettype wire

// ==== dbg_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module dbg_top (
    input  wire                                txclk,
    input  wire                                rstn,
    // AXI4-Lite slave
    input  wire  [dbg_pkg::axi_addr_w-1:0]     awaddr,
    input  wire                                awvalid,
    output logic                               awready,
    input  wire  [dbg_pkg::axi_data_w-1:0]     wdata,
    input  wire  [dbg_pkg::axi_data_w/8-1:0]   wstrb,
    input  wire                                wvalid,
    output logic                               wready,
    output logic [1:0]                         bresp,
    output logic                               bvalid,
    input  wire                                bready,
    input  wire  [dbg_pkg::axi_addr_w-1:0]     araddr,
    input  wire                                arvalid,
    output logic                               arready,
    output logic [dbg_pkg::axi_data_w-1:0]     rdata,
    output logic [1:0]                         rresp,
    output logic                               rvalid,
    input  wire                                rready,
    // probes
    input  wire  dbg_pkg::probe_a_t            probe_a,
    input  wire                                trig_a,
    input  wire  dbg_pkg::probe_b_t            probe_b,
    input  wire                                trig_b,
    // transmit port
    input  wire                                tx_ready,
    output logic                               tx_datavalid,
    output logic                               tx_datalast,
    output logic [dbg_pkg::tx_w-1:0]           tx_portdata
);
    import dbg_pkg::*;

    logic               start;
    logic [addr_w-1:0]  rd_addr;
    logic [cnt_w-1:0]   rd_count_m1;
    readout_mode_t      mode;
    logic               busy;

    dbg_buf_if #(.sample_t(probe_a_t)) bus_a ();
    dbg_buf_if #(.sample_t(probe_b_t)) bus_b ();

    dbg_axil_regs regs (
        .txclk(txclk), .rstn(rstn),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .buf_a(bus_a.regs), .buf_b(bus_b.regs),
        .start(start), .rd_addr(rd_addr), .rd_count_m1(rd_count_m1),
        .mode(mode), .busy(busy)
    );

    dbg_sample_buffer #(.sample_t(probe_a_t)) cap_a (
        .txclk(txclk), .rstn(rstn), .probe(probe_a), .trig(trig_a), .bus(bus_a.buffer)
    );

    dbg_sample_buffer #(.sample_t(probe_b_t)) cap_b (
        .txclk(txclk), .rstn(rstn), .probe(probe_b), .trig(trig_b), .bus(bus_b.buffer)
    );

    dbg_readout readout (
        .txclk(txclk), .rstn(rstn),
        .start(start), .rd_addr(rd_addr), .rd_count_m1(rd_count_m1), .mode(mode),
        .busy(busy), .buf_a(bus_a.reader), .buf_b(bus_b.reader),
        .tx_ready(tx_ready), .tx_datavalid(tx_datavalid),
        .tx_datalast(tx_datalast), .tx_portdata(tx_portdata)
    );

endmodule

`default_nettype wire

// ==== tb_dbg_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_dbg_top;
    import dbg_pkg::*;

    // enough for four captures and four 512-word readouts at half rate
    localparam int max_cycles = 12000;

    logic                    txclk;
    logic                    rstn;
    logic [axi_addr_w-1:0]   awaddr;
    logic                    awvalid;
    logic                    awready;
    logic [axi_data_w-1:0]   wdata;
    logic [axi_data_w/8-1:0] wstrb;
    logic                    wvalid;
    logic                    wready;
    logic [1:0]              bresp;
    logic                    bvalid;
    logic                    bready;
    logic [axi_addr_w-1:0]   araddr;
    logic                    arvalid;
    logic                    arready;
    logic [axi_data_w-1:0]   rdata;
    logic [1:0]              rresp;
    logic                    rvalid;
    logic                    rready;
    probe_a_t                probe_a;
    logic                    trig_a;
    probe_b_t                probe_b;
    logic                    trig_b;
    logic                    tx_ready;
    logic                    tx_datavalid;
    logic                    tx_datalast;
    logic [tx_w-1:0]         tx_portdata;

    logic [31:0]     seed;
    logic [31:0]     probe_seed;   // separate stream for the probe driver
    int              cyc;
    probe_a_t        hist_a [max_cycles];   // probe and trigger seen at each edge
    probe_b_t        hist_b [max_cycles];
    logic            trg_a [max_cycles];
    logic            trg_b [max_cycles];
    probe_a_t        mem_a [sample_depth];  // expected buffer contents
    probe_b_t        mem_b [sample_depth];
    logic [tx_w-1:0] exp_q [$];
    logic [1:0]      done_exp;

    dbg_top uut (.*);

    initial txclk = 1'b0;
    always #20 txclk = ~txclk;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] next_rand();
        seed = lcg_step(seed);
        return seed;
    endfunction

    function automatic int rand_below(input int n);
        return int'((next_rand() >> 8) % n);
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input string name, input logic [tx_w-1:0] exp,
                              input logic [tx_w-1:0] act);
        if (act !== exp)
            abort_run($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_resp(input string name, input logic [1:0] exp, input logic [1:0] act);
        if (act !== exp)
            abort_run($sformatf("Mismatch %s: expected resp %0d, actual %0d", name, exp, act));
    endtask

    task automatic check_status(input string name, input logic [2:0] exp, input logic [2:0] act);
        if (act !== exp)
            abort_run($sformatf("Mismatch %s: expected status %b, actual %b", name, exp, act));
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp)
            abort_run($sformatf("Mismatch %s: expected %b, actual %b", name, exp, act));
    endtask

    // record what the DUT sees at every edge and stop a runaway run
    always @(posedge txclk) begin
        hist_a[cyc] <= probe_a;
        hist_b[cyc] <= probe_b;
        trg_a[cyc]  <= trig_a;
        trg_b[cyc]  <= trig_b;
        cyc         <= cyc + 1;
        if (cyc == max_cycles - 1)
            abort_run($sformatf("timeout after %0d cycles, the run did not finish", max_cycles));
    end

    always @(posedge txclk) begin
        #2;
        probe_seed = lcg_step(probe_seed);
        probe_a    = probe_seed;
        probe_seed = lcg_step(probe_seed);
        probe_b    = probe_b_t'(probe_seed[31:16]);
    end

    // hs returns the index of the edge that takes address and data
    task automatic axi_write(input logic [axi_addr_w-1:0] addr, input logic [axi_data_w-1:0] data,
                             input logic [1:0] exp_resp, input string name, output int hs);
        awaddr  = addr;
        wdata   = data;
        wstrb   = '1;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = 1'b1;
        @(negedge txclk);
        while (!awready)
            @(negedge txclk);
        check_flag({name, " wready"}, 1'b1, wready);
        hs = cyc;
        @(posedge txclk);
        #2;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        @(negedge txclk);
        while (!bvalid)
            @(negedge txclk);
        check_resp(name, exp_resp, bresp);
        @(posedge txclk);
        #2;
        bready = 1'b0;
    endtask

    task automatic axi_read(input logic [axi_addr_w-1:0] addr, input logic [1:0] exp_resp,
                            input string name, output logic [axi_data_w-1:0] data);
        araddr  = addr;
        arvalid = 1'b1;
        rready  = 1'b1;
        @(negedge txclk);
        while (!arready)
            @(negedge txclk);
        @(posedge txclk);
        #2;
        arvalid = 1'b0;
        @(negedge txclk);
        while (!rvalid)
            @(negedge txclk);
        data = rdata;
        check_resp(name, exp_resp, rresp);
        @(posedge txclk);
        #2;
        rready = 1'b0;
    endtask

    task automatic read_status(input string name, input logic [2:0] exp);
        logic [axi_data_w-1:0] d;
        axi_read(reg_status, axi_resp_okay, name, d);
        check_status(name, exp, d[2:0]);
    endtask

    task automatic set_trig(input bit ch, input logic v);
        if (ch)
            trig_b = v;
        else
            trig_a = v;
    endtask

    task automatic run_capture(input bit ch, input string name);
        int                    hs;
        int                    n;
        int                    i;
        logic [axi_data_w-1:0] d;
        set_trig(ch, 1'b0);
        axi_write(reg_ctrl, ch ? 32'd2 : 32'd1, axi_resp_okay, name, hs);
        done_exp[ch] = 1'b0;
        read_status({name, " armed"}, {1'b0, done_exp});
        repeat (1 + rand_below(16)) @(posedge txclk);
        #2;
        set_trig(ch, 1'b1);
        repeat (1 + rand_below(6)) @(posedge txclk);
        #2;
        set_trig(ch, 1'b0);   // second edge lands inside the window
        repeat (1 + rand_below(6)) @(posedge txclk);
        #2;
        set_trig(ch, 1'b1);
        axi_read(reg_status, axi_resp_okay, name, d);
        while (!d[ch])
            axi_read(reg_status, axi_resp_okay, name, d);
        // first rising trigger from the second edge after the ctrl write is sample 0
        n = hs + 2;
        while (n < cyc - 1 && !(ch ? (trg_b[n] && !trg_b[n-1]) : (trg_a[n] && !trg_a[n-1])))
            n++;
        if (n + sample_depth > cyc)
            abort_run({name, ": done was set before a full window followed the trigger"});
        for (i = 0; i < sample_depth; i++) begin
            if (ch)
                mem_b[i] = hist_b[n + i];
            else
                mem_a[i] = hist_a[n + i];
        end
        done_exp[ch] = 1'b1;
        check_status({name, " done"}, {1'b0, done_exp}, d[2:0]);
    endtask

    task automatic request_readout(input string name, input logic [addr_w-1:0] addr,
                                   input logic [cnt_w-1:0] cnt_m1, input readout_mode_t mode);
        int                hs;
        int                i;
        logic [addr_w-1:0] a;
        axi_write(reg_rd_addr, axi_data_w'(addr), axi_resp_okay, name, hs);
        axi_write(reg_rd_cfg, axi_data_w'({mode, cnt_m1}), axi_resp_okay, name, hs);
        exp_q.delete();
        a = addr;
        for (i = 0; i <= int'(cnt_m1); i++) begin
            if (mode != mode_b)
                exp_q.push_back(mem_a[a]);
            if (mode != mode_a)
                exp_q.push_back({{(tx_w - 16){1'b0}}, mem_b[a]});
            a = a + 1'b1;   // wraps at 256
        end
        axi_write(reg_start, 32'd1, axi_resp_okay, name, hs);
    endtask

    task automatic collect_stream(input string name, input bit rand_ready);
        int              idx;
        logic            held;
        logic [tx_w-1:0] held_data;
        logic            held_last;
        logic [31:0]     r;
        idx  = 0;
        held = 1'b0;
        while (idx < exp_q.size()) begin
            @(negedge txclk);
            if (held) begin
                check_flag({name, " valid held"}, 1'b1, tx_datavalid);
                check_word({name, " data held"}, held_data, tx_portdata);
                check_flag({name, " last held"}, held_last, tx_datalast);
            end
            held = 1'b0;
            if (tx_datavalid && tx_ready) begin
                check_word($sformatf("%s word %0d", name, idx), exp_q[idx], tx_portdata);
                check_flag($sformatf("%s last %0d", name, idx), idx == exp_q.size() - 1,
                           tx_datalast);
                idx++;
            end else if (tx_datavalid) begin
                held      = 1'b1;
                held_data = tx_portdata;
                held_last = tx_datalast;
            end
            @(posedge txclk);
            #2;
            r        = next_rand();
            tx_ready = rand_ready ? r[20] : 1'b1;
        end
        tx_ready = 1'b1;
        repeat (8) begin
            @(negedge txclk);
            check_flag({name, " no extra word"}, 1'b0, tx_datavalid);
        end
        @(posedge txclk);
        #2;
        read_status({name, " idle"}, {1'b0, done_exp});
    endtask

    initial begin
        logic [axi_data_w-1:0] d;
        int                    hs;
        seed       = 32'hc776974f;
        probe_seed = lcg_step(32'hc776974f);
        cyc        = 0;
        done_exp   = 2'b00;
        rstn       = 1'b0;
        awaddr     = '0;
        awvalid    = 1'b0;
        wdata      = '0;
        wstrb      = '0;
        wvalid     = 1'b0;
        bready     = 1'b0;
        araddr     = '0;
        arvalid    = 1'b0;
        rready     = 1'b0;
        probe_a    = '0;
        probe_b    = '0;
        trig_a     = 1'b0;
        trig_b     = 1'b0;
        tx_ready   = 1'b0;
        repeat (3) @(posedge txclk);
        #2;
        rstn = 1'b1;

        read_status("status after reset", 3'b000);
        check_flag("tx_datavalid after reset", 1'b0, tx_datavalid);
        axi_read(5'h14, axi_resp_slverr, "read of unknown offset", d);
        check_word("read of unknown offset", '0, d);
        axi_write(reg_rd_addr, 32'h0000_005a, axi_resp_okay, "rd_addr setup", hs);
        axi_write(reg_rd_cfg, 32'h0000_0123, axi_resp_okay, "rd_cfg setup", hs);
        axi_write(5'h14, 32'hffff_ffff, axi_resp_slverr, "write of unknown offset", hs);
        axi_read(reg_rd_addr, axi_resp_okay, "rd_addr after bad write", d);
        check_word("rd_addr after bad write", 32'h0000_005a, d);
        axi_read(reg_rd_cfg, axi_resp_okay, "rd_cfg after bad write", d);
        check_word("rd_cfg after bad write", 32'h0000_0123, d);
        read_status("status after bad write", 3'b000);

        run_capture(1'b0, "capture a");
        tx_ready = 1'b1;
        request_readout("mode_a readout", addr_w'(rand_below(256)), cnt_w'(rand_below(256)),
                        mode_a);
        collect_stream("mode_a readout", 1'b0);

        run_capture(1'b1, "capture b");
        request_readout("mode_b wrap", addr_w'(200 + rand_below(56)),
                        cnt_w'(60 + rand_below(100)), mode_b);
        collect_stream("mode_b wrap", 1'b0);

        request_readout("mode_ab readout", addr_w'(rand_below(256)), cnt_w'(rand_below(256)),
                        mode_ab);
        collect_stream("mode_ab readout", 1'b1);

        // long stream stalled so busy can be seen and a second start dropped
        tx_ready = 1'b0;
        request_readout("long mode_ab", addr_w'(rand_below(256)), 8'd255, mode_ab);
        read_status("busy during stream", {1'b1, done_exp});
        axi_write(reg_rd_cfg, axi_data_w'({mode_a, 8'd3}), axi_resp_okay, "cfg while busy", hs);
        axi_write(reg_start, 32'd1, axi_resp_okay, "start while busy", hs);
        collect_stream("long mode_ab", 1'b1);

        run_capture(1'b0, "re-arm a");
        request_readout("mode_a after re-arm", addr_w'(rand_below(256)),
                        cnt_w'(rand_below(256)), mode_a);
        collect_stream("mode_a after re-arm", 1'b1);

        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
dbg_pkg.sv
dbg_buf_if.sv
dbg_axil_regs.sv
dbg_sample_buffer.sv
dbg_readout.sv
dbg_top.sv
tb_dbg_top.sv
